// File: hdl/bp_pkg.sv
`default_nettype none

package bp_pkg;

	// a fetch group holds two instructions of four bytes each
	localparam int fetch_num = 2;
	localparam int slot_bits = 1;

	localparam int addr_width = 32;

	// byte offset of an instruction word inside the address
	localparam int slot_offset = 2;

	localparam int group_bytes = fetch_num * 4;

	localparam int btb_entries = 32;
	localparam int bht_entries = 64;

	typedef logic [addr_width-1:0] virt_t;

	typedef logic [slot_bits-1:0] slot_t;

	// the top bit of the counter is the taken prediction
	typedef enum logic [1:0] {
		strong_nt = 2'b00,
		weak_nt   = 2'b01,
		weak_t    = 2'b10,
		strong_t  = 2'b11
	} counter_t;

endpackage

`default_nettype wire

// File: hdl/bht.sv
`default_nettype none

module bht #(
	// must be a multiple of the fetch width
	parameter int entries = bp_pkg::bht_entries
) (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire logic                          flush,
	input  wire bp_pkg::virt_t                 pc,
	input  wire logic                          update_valid,
	input  wire bp_pkg::virt_t                 update_pc,
	input  wire logic                          update_taken,
	output logic [bp_pkg::fetch_num-1:0]       slot_taken
);

	localparam int rows      = entries / bp_pkg::fetch_num;
	localparam int row_bits  = $clog2(rows);
	localparam int index_lsb = bp_pkg::slot_offset + bp_pkg::slot_bits;

	logic             valid   [rows][bp_pkg::fetch_num];
	bp_pkg::counter_t counter [rows][bp_pkg::fetch_num];

	logic [row_bits-1:0] index;
	logic [row_bits-1:0] update_index;
	bp_pkg::slot_t       update_slot;

	assign index        = pc[index_lsb +: row_bits];
	assign update_index = update_pc[index_lsb +: row_bits];
	assign update_slot  = update_pc[bp_pkg::slot_offset +: bp_pkg::slot_bits];

	// a taken outcome from either weak state jumps straight to strong taken
	function automatic bp_pkg::counter_t step_counter(
		input bp_pkg::counter_t cur,
		input logic             taken
	);
		bp_pkg::counter_t nxt;
		if (taken) begin
			unique case (cur)
				bp_pkg::strong_nt: nxt = bp_pkg::weak_nt;
				bp_pkg::weak_nt:   nxt = bp_pkg::strong_t;
				bp_pkg::weak_t:    nxt = bp_pkg::strong_t;
				bp_pkg::strong_t:  nxt = bp_pkg::strong_t;
			endcase
		end else begin
			unique case (cur)
				bp_pkg::strong_nt: nxt = bp_pkg::strong_nt;
				bp_pkg::weak_nt:   nxt = bp_pkg::strong_nt;
				bp_pkg::weak_t:    nxt = bp_pkg::strong_nt;
				bp_pkg::strong_t:  nxt = bp_pkg::weak_t;
			endcase
		end
		return nxt;
	endfunction

	for (genvar i = 0; i < bp_pkg::fetch_num; i++) begin : gen_slot_taken
		assign slot_taken[i] = valid[index][i] && counter[index][i][1];
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int r = 0; r < rows; r++) begin
				for (int s = 0; s < bp_pkg::fetch_num; s++) begin
					valid[r][s]   <= 1'b0;
					counter[r][s] <= bp_pkg::strong_nt;
				end
			end
		end else if (flush) begin
			// after a flush one taken update is enough to predict taken again
			for (int r = 0; r < rows; r++) begin
				for (int s = 0; s < bp_pkg::fetch_num; s++) begin
					valid[r][s]   <= 1'b0;
					counter[r][s] <= bp_pkg::weak_t;
				end
			end
		end else if (update_valid) begin
			valid[update_index][update_slot]   <= 1'b1;
			counter[update_index][update_slot] <= step_counter(
				counter[update_index][update_slot], update_taken);
		end
	end

endmodule

`default_nettype wire

// File: hdl/btb.sv
`default_nettype none

module btb #(
	parameter int entries = bp_pkg::btb_entries
) (
	input  wire logic                                  clk,
	input  wire logic                                  rst,
	input  wire logic                                  flush,
	input  wire bp_pkg::virt_t                         pc,
	input  wire logic                                  update_valid,
	input  wire bp_pkg::virt_t                         update_pc,
	input  wire logic                                  update_taken,
	input  wire bp_pkg::virt_t                         update_target,
	output logic          [bp_pkg::fetch_num-1:0]      slot_hit,
	output bp_pkg::virt_t [bp_pkg::fetch_num-1:0]      slot_target
);

	localparam int rows      = entries / bp_pkg::fetch_num;
	localparam int row_bits  = $clog2(rows);
	localparam int index_lsb = bp_pkg::slot_offset + bp_pkg::slot_bits;
	localparam int tag_lsb   = index_lsb + row_bits;
	localparam int tag_bits  = bp_pkg::addr_width - tag_lsb;

	logic                valid   [rows][bp_pkg::fetch_num];
	logic [tag_bits-1:0] tags    [rows][bp_pkg::fetch_num];
	bp_pkg::virt_t       targets [rows][bp_pkg::fetch_num];

	logic [row_bits-1:0] index;
	logic [tag_bits-1:0] pc_tag;

	logic [row_bits-1:0] update_index;
	logic [tag_bits-1:0] update_tag;
	bp_pkg::slot_t       update_slot;
	logic                write_en;

	assign index  = pc[index_lsb +: row_bits];
	assign pc_tag = pc[tag_lsb +: tag_bits];

	assign update_index = update_pc[index_lsb +: row_bits];
	assign update_tag   = update_pc[tag_lsb +: tag_bits];
	assign update_slot  = update_pc[bp_pkg::slot_offset +: bp_pkg::slot_bits];

	// only taken branches allocate and a flush in the same cycle drops the write
	assign write_en = update_valid && update_taken && !flush;

	for (genvar i = 0; i < bp_pkg::fetch_num; i++) begin : gen_slot_read
		assign slot_hit[i]    = valid[index][i] && (tags[index][i] == pc_tag);
		assign slot_target[i] = targets[index][i];
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int r = 0; r < rows; r++) begin
				for (int s = 0; s < bp_pkg::fetch_num; s++) begin
					valid[r][s] <= 1'b0;
				end
			end
		end else if (flush) begin
			for (int r = 0; r < rows; r++) begin
				for (int s = 0; s < bp_pkg::fetch_num; s++) begin
					valid[r][s] <= 1'b0;
				end
			end
		end else if (write_en) begin
			valid[update_index][update_slot] <= 1'b1;
		end
	end

	// taken updates write the tag and the target of the addressed slot
	always_ff @(posedge clk) begin
		if (write_en) begin
			tags[update_index][update_slot]    <= update_tag;
			targets[update_index][update_slot] <= update_target;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fetch_target_sel.sv
`default_nettype none

module fetch_target_sel (
	input  wire bp_pkg::virt_t                         pc,
	input  wire logic          [bp_pkg::fetch_num-1:0] slot_taken,
	input  wire logic          [bp_pkg::fetch_num-1:0] slot_hit,
	input  wire bp_pkg::virt_t [bp_pkg::fetch_num-1:0] slot_target,
	output logic                                       pred_taken,
	output bp_pkg::slot_t                              pred_slot,
	output bp_pkg::virt_t                              next_pc
);

	bp_pkg::slot_t                  fetch_slot;
	bp_pkg::virt_t                  group_base;
	bp_pkg::virt_t                  fall_through;
	logic [bp_pkg::fetch_num-1:0]   slot_valid;
	logic [bp_pkg::fetch_num-1:0]   candidate;

	assign fetch_slot   = pc[bp_pkg::slot_offset +: bp_pkg::slot_bits];
	assign group_base   = pc & ~bp_pkg::virt_t'(bp_pkg::group_bytes - 1);
	assign fall_through = group_base + bp_pkg::virt_t'(bp_pkg::group_bytes);

	// fetch enters the group at fetch_slot so earlier slots are not executed
	always_comb begin
		for (int i = 0; i < bp_pkg::fetch_num; i++) begin
			slot_valid[i] = (i >= int'(fetch_slot));
		end
	end

	// a slot needs both a taken counter and a matching target
	assign candidate = slot_taken & slot_hit & slot_valid;

	always_comb begin
		pred_taken = 1'b0;
		pred_slot  = '0;
		next_pc    = fall_through;
		// walk downwards so the lowest candidate is the one left standing
		for (int i = bp_pkg::fetch_num - 1; i >= 0; i--) begin
			if (candidate[i]) begin
				pred_taken = 1'b1;
				pred_slot  = bp_pkg::slot_t'(i);
				next_pc    = slot_target[i];
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/branch_predictor.sv
`default_nettype none

module branch_predictor (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          flush,
	input  wire bp_pkg::virt_t pc,
	input  wire logic          update_valid,
	input  wire bp_pkg::virt_t update_pc,
	input  wire logic          update_taken,
	input  wire bp_pkg::virt_t update_target,
	output logic               pred_taken,
	output bp_pkg::slot_t      pred_slot,
	output bp_pkg::virt_t      next_pc
);

	logic          [bp_pkg::fetch_num-1:0] slot_taken;
	logic          [bp_pkg::fetch_num-1:0] slot_hit;
	bp_pkg::virt_t [bp_pkg::fetch_num-1:0] slot_target;

	// direction from the counters
	bht u_bht (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.pc           (pc),
		.update_valid (update_valid),
		.update_pc    (update_pc),
		.update_taken (update_taken),
		.slot_taken   (slot_taken)
	);

	// targets of branches seen taken before
	btb u_btb (
		.clk           (clk),
		.rst           (rst),
		.flush         (flush),
		.pc            (pc),
		.update_valid  (update_valid),
		.update_pc     (update_pc),
		.update_taken  (update_taken),
		.update_target (update_target),
		.slot_hit      (slot_hit),
		.slot_target   (slot_target)
	);

	fetch_target_sel u_fetch_target_sel (
		.pc          (pc),
		.slot_taken  (slot_taken),
		.slot_hit    (slot_hit),
		.slot_target (slot_target),
		.pred_taken  (pred_taken),
		.pred_slot   (pred_slot),
		.next_pc     (next_pc)
	);

endmodule

`default_nettype wire

// File: bench/branch_predictor_properties.sv
`default_nettype none

module branch_predictor_properties (
	input wire logic          clk,
	input wire logic          rst,
	input wire logic          flush,
	input wire logic          update_valid,
	input wire logic          pred_taken,
	input wire bp_pkg::virt_t next_pc
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	// targets and fall-through addresses are instruction addresses
	assert property (@(posedge clk) disable iff (rst) next_pc[1:0] == 2'b00)
	else begin
		fail_count = fail_count + 1;
		$error("next_pc is not word aligned");
	end

	// a flush invalidates both tables, so nothing can predict taken right after it
	assert property (@(posedge clk) disable iff (rst) flush |=> (!pred_taken || update_valid))
	else begin
		fail_count = fail_count + 1;
		$error("pred_taken high in the cycle after a flush");
	end

	assert property (@(posedge clk) rst |-> !pred_taken)
	else begin
		fail_count = fail_count + 1;
		$error("pred_taken high during reset");
	end

endmodule

bind branch_predictor branch_predictor_properties u_properties (
	.clk          (clk),
	.rst          (rst),
	.flush        (flush),
	.update_valid (update_valid),
	.pred_taken   (pred_taken),
	.next_pc      (next_pc)
);

`default_nettype wire

// File: bench/tb_branch_predictor.sv
`default_nettype none

module tb_branch_predictor;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int op_lookup       = 0;
	localparam int op_update       = 1;
	localparam int op_flush        = 2;
	localparam int op_flush_update = 3;

	localparam int reset_cycles = 10;
	localparam int random_count = 64;

	logic          clk;
	logic          rst;
	logic          flush;
	bp_pkg::virt_t pc;
	logic          update_valid;
	bp_pkg::virt_t update_pc;
	logic          update_taken;
	bp_pkg::virt_t update_target;
	logic          pred_taken;
	bp_pkg::slot_t pred_slot;
	bp_pkg::virt_t next_pc;

	// each row of the table is spread over these parallel queues
	int            tbl_op[$];
	bp_pkg::virt_t tbl_pc[$];
	logic          tbl_taken[$];
	bp_pkg::virt_t tbl_target[$];
	logic          tbl_exp_taken[$];
	bp_pkg::slot_t tbl_exp_slot[$];
	bp_pkg::virt_t tbl_exp_next[$];

	int seed        = 87;
	int cycle_count = 0;
	int cycle_limit = 0;

	branch_predictor u_branch_predictor (
		.clk           (clk),
		.rst           (rst),
		.flush         (flush),
		.pc            (pc),
		.update_valid  (update_valid),
		.update_pc     (update_pc),
		.update_taken  (update_taken),
		.update_target (update_target),
		.pred_taken    (pred_taken),
		.pred_slot     (pred_slot),
		.next_pc       (next_pc)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("Test failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// without a taken prediction fetch continues with the next aligned group
	function automatic bp_pkg::virt_t fall_through_pc(input bp_pkg::virt_t addr);
		return (addr & ~32'h0000_0007) + 32'd8;
	endfunction

	task automatic check_value(input string name, input bp_pkg::virt_t expected,
		input bp_pkg::virt_t actual);
		if (actual !== expected) begin
			$display("ERR at %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("Test failed");
			$fatal(1, "stopping on a mismatch");
		end
	endtask

	task automatic add_row(input int op, input bp_pkg::virt_t addr, input logic taken,
		input bp_pkg::virt_t target, input logic exp_taken, input bp_pkg::slot_t exp_slot,
		input bp_pkg::virt_t exp_next);
		tbl_op.push_back(op);
		tbl_pc.push_back(addr);
		tbl_taken.push_back(taken);
		tbl_target.push_back(target);
		tbl_exp_taken.push_back(exp_taken);
		tbl_exp_slot.push_back(exp_slot);
		tbl_exp_next.push_back(exp_next);
	endtask

	task automatic add_lookup(input bp_pkg::virt_t addr, input logic exp_taken,
		input bp_pkg::slot_t exp_slot, input bp_pkg::virt_t exp_next);
		add_row(op_lookup, addr, 1'b0, 32'h0, exp_taken, exp_slot, exp_next);
	endtask

	task automatic add_update(input bp_pkg::virt_t addr, input logic taken,
		input bp_pkg::virt_t target);
		add_row(op_update, addr, taken, target, 1'b0, 1'b0, 32'h0);
	endtask

	task automatic build_table();
		// after reset nothing predicts taken
		add_lookup(32'h0000_0000, 1'b0, 1'b0, 32'h0000_0008);
		add_lookup(32'h0000_1004, 1'b0, 1'b0, 32'h0000_1008);
		add_lookup(32'h0000_3a4c, 1'b0, 1'b0, 32'h0000_3a50);
		add_lookup(32'h8000_fff4, 1'b0, 1'b0, 32'h8000_fff8);
		add_lookup(32'hffff_fffc, 1'b0, 1'b0, 32'h0000_0000);
		// counter walk of one slot 0 branch
		add_update(32'h0000_1000, 1'b1, 32'h0000_2000);
		add_lookup(32'h0000_1000, 1'b0, 1'b0, 32'h0000_1008);
		add_update(32'h0000_1000, 1'b1, 32'h0000_2000);
		add_lookup(32'h0000_1000, 1'b1, 1'b0, 32'h0000_2000);
		add_update(32'h0000_1000, 1'b0, 32'h0000_0000);
		add_lookup(32'h0000_1000, 1'b1, 1'b0, 32'h0000_2000);
		add_update(32'h0000_1000, 1'b0, 32'h0000_0000);
		add_lookup(32'h0000_1000, 1'b0, 1'b0, 32'h0000_1008);
		// both slots of one group trained
		add_update(32'h0000_1040, 1'b1, 32'h0000_3000);
		add_update(32'h0000_1040, 1'b1, 32'h0000_3000);
		add_update(32'h0000_1044, 1'b1, 32'h0000_4000);
		add_update(32'h0000_1044, 1'b1, 32'h0000_4000);
		add_lookup(32'h0000_1040, 1'b1, 1'b0, 32'h0000_3000);
		add_lookup(32'h0000_1044, 1'b1, 1'b1, 32'h0000_4000);
		// only slot 1 trained
		add_update(32'h0000_1024, 1'b1, 32'h0000_5000);
		add_update(32'h0000_1024, 1'b1, 32'h0000_5000);
		add_lookup(32'h0000_1020, 1'b1, 1'b1, 32'h0000_5000);
		add_lookup(32'h0000_1024, 1'b1, 1'b1, 32'h0000_5000);
		// bit 8 is part of the tag only, so these alias in both tables and miss
		add_lookup(32'h0000_1140, 1'b0, 1'b0, 32'h0000_1148);
		add_lookup(32'h0000_1144, 1'b0, 1'b0, 32'h0000_1148);
		add_row(op_flush, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0);
		add_lookup(32'h0000_1040, 1'b0, 1'b0, 32'h0000_1048);
		add_lookup(32'h0000_1044, 1'b0, 1'b0, 32'h0000_1048);
		add_lookup(32'h0000_1020, 1'b0, 1'b0, 32'h0000_1028);
		// counters sit at weak taken after a flush so one update is enough
		add_update(32'h0000_1040, 1'b1, 32'h0000_3000);
		add_lookup(32'h0000_1040, 1'b1, 1'b0, 32'h0000_3000);
		add_lookup(32'h0000_1044, 1'b0, 1'b0, 32'h0000_1048);
		add_row(op_flush_update, 32'h0000_1024, 1'b1, 32'h0000_5000, 1'b0, 1'b0, 32'h0);
		add_lookup(32'h0000_1020, 1'b0, 1'b0, 32'h0000_1028);
		add_lookup(32'h0000_1040, 1'b0, 1'b0, 32'h0000_1048);
		add_update(32'h0000_1024, 1'b1, 32'h0000_5000);
		add_lookup(32'h0000_1020, 1'b1, 1'b1, 32'h0000_5000);
	endtask

	task automatic apply_row(input int op, input bp_pkg::virt_t addr, input logic taken,
		input bp_pkg::virt_t target, input logic exp_taken, input bp_pkg::slot_t exp_slot,
		input bp_pkg::virt_t exp_next);
		@(negedge clk);
		flush         = 1'b0;
		update_valid  = 1'b0;
		update_pc     = 32'h0;
		update_taken  = 1'b0;
		update_target = 32'h0;
		if (op == op_lookup) begin
			pc = addr;
			#2;
			check_value("pred_taken", 32'(exp_taken), 32'(pred_taken));
			check_value("pred_slot", 32'(exp_slot), 32'(pred_slot));
			check_value("next_pc", exp_next, next_pc);
		end else begin
			flush = (op == op_flush || op == op_flush_update);
			if (op == op_update || op == op_flush_update) begin
				update_valid  = 1'b1;
				update_pc     = addr;
				update_taken  = taken;
				update_target = target;
			end
		end
	endtask

	initial begin
		bp_pkg::virt_t addr;
		rst           = 1'b1;
		flush         = 1'b0;
		pc            = 32'h0;
		update_valid  = 1'b0;
		update_pc     = 32'h0;
		update_taken  = 1'b0;
		update_target = 32'h0;
		build_table();
		cycle_limit = 4 * (tbl_op.size() + random_count + 1 + 2 * reset_cycles);
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < tbl_op.size(); i++) begin
			apply_row(tbl_op[i], tbl_pc[i], tbl_taken[i], tbl_target[i],
				tbl_exp_taken[i], tbl_exp_slot[i], tbl_exp_next[i]);
		end
		// the slot 1 branch at 1024 is trained here and reset clears it without a clock edge
		@(negedge clk);
		pc  = 32'h0000_1020;
		rst = 1'b1;
		#2;
		check_value("pred_taken", 32'h0, 32'(pred_taken));
		check_value("pred_slot", 32'h0, 32'(pred_slot));
		check_value("next_pc", 32'h0000_1028, next_pc);
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// random fetch addresses after a flush must all fall through
		apply_row(op_flush, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0);
		for (int i = 0; i < random_count; i++) begin
			addr = bp_pkg::virt_t'($random(seed)) & ~32'h0000_0003;
			apply_row(op_lookup, addr, 1'b0, 32'h0, 1'b0, 1'b0, fall_through_pc(addr));
		end
		repeat (2) @(negedge clk);
		if (u_branch_predictor.u_properties.fail_count == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("assertion failures: %0d", u_branch_predictor.u_properties.fail_count);
			$display("Test failed");
			$fatal(1, "assertions failed during the run");
		end
	end

endmodule

`default_nettype wire

// File: files.f
hdl/bp_pkg.sv
hdl/bht.sv
hdl/btb.sv
hdl/fetch_target_sel.sv
hdl/branch_predictor.sv
bench/branch_predictor_properties.sv
bench/tb_branch_predictor.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_branch_predictor -f files.f -o sim

status=0
output=$(./obj_dir/sim +verilator+error+limit+100) || status=$?
echo "$output"

if echo "$output" | grep -qx "Test completed successfully"; then
	exit 0
fi
echo "simulation exit status $status, pass line not found"
exit 1
